//--- Makefile
SIM  := obj_dir/Vtb_cpu
SRCS := $(wildcard rtl/*.sv rtl/*.svh verification/*.sv)

.PHONY: all run clean

all: run

$(SIM): src.f $(SRCS)
	verilator --binary --assert --top-module tb_cpu -f src.f

run: $(SIM)
	-./$(SIM) > sim.log 2>&1
	@cat sim.log
	@if grep -qF '*** TEST FAILED ***' sim.log; then \
		echo "simulation failed, see sim.log"; exit 1; \
	elif ! grep -qF '*** TEST PASSED ***' sim.log; then \
		echo "no result found in sim.log"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

//--- rtl/alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module alu (
    input  logic [`CPU_WORD_W-1:0] left,
    input  logic [`CPU_WORD_W-1:0] right,
    input  cpu_pkg::alu_op_e       op,
    input  logic                   carry_in,
    output logic [`CPU_WORD_W-1:0] result,
    output logic [3:0]             flags_out
);
    import cpu_pkg::*;

    localparam int MSB = `CPU_WORD_W - 1;

    logic [`CPU_WORD_W:0] wide;         // extra bit holds carry/borrow
    logic [`CPU_WORD_W:0] cin_ext;
    logic                 carry;
    logic                 ovf;

    assign cin_ext = {{`CPU_WORD_W{1'b0}}, carry_in};

    always_comb begin
        wide   = '0;
        result = '0;
        carry  = 1'b0;
        ovf    = 1'b0;
        case (op)
            alu_adc: begin
                wide   = {1'b0, left} + {1'b0, right} + cin_ext;
                result = wide[MSB:0];
                carry  = wide[`CPU_WORD_W];
                ovf    = (left[MSB] == right[MSB]) && (result[MSB] != left[MSB]);
            end
            alu_sbb1: begin
                wide   = {1'b0, left} - {1'b0, right} - cin_ext;
                result = wide[MSB:0];
                carry  = wide[`CPU_WORD_W];                 // borrow
                ovf    = (left[MSB] != right[MSB]) && (result[MSB] != left[MSB]);
            end
            alu_sbb2: begin
                wide   = {1'b0, right} - {1'b0, left} - cin_ext;
                result = wide[MSB:0];
                carry  = wide[`CPU_WORD_W];
                ovf    = (right[MSB] != left[MSB]) && (result[MSB] != right[MSB]);
            end
            alu_not: result = ~left;
            alu_and: result = left & right;
            alu_or:  result = left | right;                 // also the move path
            alu_xor: result = left ^ right;
            alu_shl: begin
                result = {left[MSB-1:0], 1'b0};
                carry  = left[MSB];                         // bit shifted out
            end
            alu_shr: begin
                result = {1'b0, left[MSB:1]};
                carry  = left[0];
            end
            alu_sar: begin
                result = {left[MSB], left[MSB:1]};          // sign kept
                carry  = left[0];
            end
            default: ;
        endcase
    end

    always_comb begin
        flags_out              = '0;
        flags_out[`CPU_FLAG_C] = carry;
        flags_out[`CPU_FLAG_Z] = (result == '0);
        flags_out[`CPU_FLAG_S] = result[MSB];
        flags_out[`CPU_FLAG_O] = ovf;
    end

endmodule

`default_nettype wire

//--- rtl/control_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module control_unit (
    input  logic                   clk,
    input  logic                   rst,
    input  cpu_pkg::instr_t        ri,
    input  logic [`CPU_WORD_W-1:0] ind,
    output cpu_pkg::alu_op_e       alu_op,
    output logic                   alu_carry,
    output logic                   alu_oe,
    output logic                   t1_oe,
    output logic                   t1_we,
    output logic                   t2_oe,
    output logic                   t2_we,
    output logic [`CPU_REG_AW-1:0] regs_addr,
    output logic                   regs_oe,
    output logic                   regs_we,
    output logic                   cp_oe,
    output logic                   cp_we,
    output logic                   am_oe,
    output logic                   am_we,
    output logic                   ram_oe,
    output logic                   ri_we,
    output logic                   ind_we
);
    import cpu_pkg::*;

    typedef enum logic [3:0] {
        st_reset, st_fetch_0, st_fetch_1, st_fetch_2, st_decode,
        st_load_src_reg, st_load_dst_reg, st_exec_1op, st_exec_2op,
        st_store_reg, st_inc_cp_0, st_inc_cp_1
    } state_e;

    state_e     state;
    state_e     state_next;
    state_e     exec_q;                             // execute state chosen at decode
    logic       dir_q;                              // latched direction bit
    logic       store_q;                            // result goes back to a register

    logic       two_op;
    logic       defined;
    logic [2:0] oper;

    assign two_op = ri.opcode[5];
    assign oper   = ri.opcode[2:0];

    // register mode, no immediate, and a known operation in its class
    assign defined = (ri.mode == 2'b11) && !ri.opcode[4] && (oper != 3'b111)
                     && (two_op || ri.opcode[3] || (oper == 3'b000));

    always_ff @(posedge clk) begin
        if (!rst) begin
            state   <= st_reset;
            exec_q  <= st_exec_1op;
            dir_q   <= 1'b0;
            store_q <= 1'b0;
        end else begin
            state <= state_next;
            if (state == st_decode) begin
                exec_q  <= two_op ? st_exec_2op : st_exec_1op;
                dir_q   <= (two_op || !ri.opcode[3]) ? ri.d : 1'b0;  // 1-op writes rm
                store_q <= !two_op || ri.opcode[3];
            end
        end
    end

    always_comb begin
        state_next = state;
        alu_op     = alu_adc;
        alu_carry  = 1'b0;
        alu_oe     = 1'b0;
        t1_oe      = 1'b0;
        t1_we      = 1'b0;
        t2_oe      = 1'b0;
        t2_we      = 1'b0;
        regs_addr  = '0;
        regs_oe    = 1'b0;
        regs_we    = 1'b0;
        cp_oe      = 1'b0;
        cp_we      = 1'b0;
        am_oe      = 1'b0;
        am_we      = 1'b0;
        ram_oe     = 1'b0;
        ri_we      = 1'b0;
        ind_we     = 1'b0;

        case (state)
            st_reset: state_next = st_fetch_0;

            ////////////////////
            // instruction fetch

            st_fetch_0: begin
                cp_oe      = 1'b1;                  // AM <= CP
                am_we      = 1'b1;
                state_next = st_fetch_1;
            end
            st_fetch_1: begin
                am_oe      = 1'b1;                  // memory read strobe
                state_next = st_fetch_2;
            end
            st_fetch_2: begin
                ram_oe     = 1'b1;
                ri_we      = 1'b1;
                state_next = st_decode;
            end
            st_decode: state_next = defined ? st_load_src_reg : st_inc_cp_0;

            ////////////////////
            // operands, execute, store

            st_load_src_reg: begin
                regs_addr  = dir_q ? ri.rm : ri.reg_f;
                regs_oe    = 1'b1;
                t2_we      = 1'b1;
                state_next = st_load_dst_reg;
            end
            st_load_dst_reg: begin
                regs_addr  = dir_q ? ri.reg_f : ri.rm;
                regs_oe    = 1'b1;
                t1_we      = 1'b1;
                state_next = exec_q;
            end
            st_exec_1op: begin
                if (ri.opcode[3]) begin
                    t1_oe  = 1'b1;
                    ind_we = 1'b1;
                    case (oper)
                        3'b000: begin               // INC
                            alu_op    = alu_adc;
                            alu_carry = 1'b1;
                        end
                        3'b001: begin               // DEC
                            alu_op    = alu_sbb1;
                            alu_carry = 1'b1;
                        end
                        3'b010:  alu_op = alu_sbb2; // NEG, 0 - T1
                        3'b011:  alu_op = alu_not;
                        3'b100:  alu_op = alu_shl;
                        3'b101:  alu_op = alu_shr;
                        default: alu_op = alu_sar;
                    endcase
                end else begin
                    t2_oe  = 1'b1;                  // MOV, source passes through
                    alu_op = alu_or;
                end
                alu_oe     = 1'b1;
                t1_we      = 1'b1;
                state_next = store_q ? st_store_reg : st_inc_cp_0;
            end
            st_exec_2op: begin
                t1_oe = 1'b1;
                t2_oe = 1'b1;
                case (oper)
                    3'b000:  alu_op = alu_adc;      // ADD
                    3'b001: begin                   // ADC
                        alu_op    = alu_adc;
                        alu_carry = ind[`CPU_FLAG_C];
                    end
                    3'b010:  alu_op = alu_sbb1;     // SUB / CMP
                    3'b011: begin                   // SBB
                        alu_op    = alu_sbb1;
                        alu_carry = ind[`CPU_FLAG_C];
                    end
                    3'b100:  alu_op = alu_and;      // AND / TEST
                    3'b101:  alu_op = alu_or;
                    default: alu_op = alu_xor;
                endcase
                alu_oe     = 1'b1;
                t1_we      = 1'b1;
                ind_we     = 1'b1;
                state_next = store_q ? st_store_reg : st_inc_cp_0;
            end
            st_store_reg: begin
                t1_oe      = 1'b1;
                alu_op     = alu_or;                // T1 | 0
                alu_oe     = 1'b1;
                regs_addr  = dir_q ? ri.reg_f : ri.rm;
                regs_we    = 1'b1;
                state_next = st_inc_cp_0;
            end

            ////////////////////
            // CP <= CP + 1 through T1 and the ALU

            st_inc_cp_0: begin
                cp_oe      = 1'b1;
                t1_we      = 1'b1;
                state_next = st_inc_cp_1;
            end
            st_inc_cp_1: begin
                t1_oe      = 1'b1;
                alu_op     = alu_adc;
                alu_carry  = 1'b1;
                alu_oe     = 1'b1;
                cp_we      = 1'b1;
                state_next = st_fetch_0;
            end
            default: state_next = st_reset;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

////////////////////
// word and register file sizing

`define CPU_WORD_W      16              // data and instruction width
`define CPU_REG_AW      3               // register index width
`define CPU_NUM_REGS    8               // general purpose registers

// program counter value after reset
`define CPU_RESET_PC    16'h0000

////////////////////
// bit positions inside the IND word, all higher bits read as zero

`define CPU_FLAG_C      0               // carry or borrow out
`define CPU_FLAG_Z      1               // zero result
`define CPU_FLAG_S      2               // sign of result
`define CPU_FLAG_O      3               // signed overflow

`endif

//--- rtl/cpu_pkg.sv
`default_nettype none

`include "cpu_cfg.svh"

package cpu_pkg;

    // ALU functions selected by the control unit
    typedef enum logic [3:0] {
        alu_adc  = 4'd0,                // left + right + carry
        alu_sbb1 = 4'd1,                // left - right - carry
        alu_sbb2 = 4'd2,                // right - left - carry
        alu_not  = 4'd3,
        alu_and  = 4'd4,
        alu_or   = 4'd5,
        alu_xor  = 4'd6,
        alu_shl  = 4'd7,                // shifts act on left only
        alu_shr  = 4'd8,
        alu_sar  = 4'd9
    } alu_op_e;

    // instruction word, msb first
    typedef struct packed {
        logic [6:0]             opcode; // class, imm, arith/store, operation
        logic                   d;      // direction bit
        logic [1:0]             mode;   // 11 = register operands
        logic [`CPU_REG_AW-1:0] reg_f;
        logic [`CPU_REG_AW-1:0] rm;
    } instr_t;

endpackage

`default_nettype wire

//--- rtl/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module cpu_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`CPU_WORD_W-1:0] mem_rdata,
    output logic [`CPU_WORD_W-1:0] mem_addr,
    output logic                   mem_rd,
    output logic                   reg_wr,
    output logic [`CPU_REG_AW-1:0] reg_wr_addr,
    output logic [`CPU_WORD_W-1:0] reg_wr_data,
    output logic [`CPU_WORD_W-1:0] flags
);
    import cpu_pkg::*;

    alu_op_e                alu_op;
    instr_t                 ri;
    logic                   alu_carry, alu_oe;
    logic                   t1_oe, t1_we, t2_oe, t2_we;
    logic [`CPU_REG_AW-1:0] regs_addr;
    logic                   regs_oe, regs_we;
    logic                   cp_oe, cp_we, am_oe, am_we;
    logic                   ram_oe, ri_we, ind_we;

    assign mem_rd = am_oe;                          // read strobe is the AM output enable

    control_unit u_control_unit (
        .clk (clk), .rst (rst), .ri (ri), .ind (flags),
        .alu_op (alu_op), .alu_carry (alu_carry), .alu_oe (alu_oe),
        .t1_oe (t1_oe), .t1_we (t1_we), .t2_oe (t2_oe), .t2_we (t2_we),
        .regs_addr (regs_addr), .regs_oe (regs_oe), .regs_we (regs_we),
        .cp_oe (cp_oe), .cp_we (cp_we), .am_oe (am_oe), .am_we (am_we),
        .ram_oe (ram_oe), .ri_we (ri_we), .ind_we (ind_we)
    );

    datapath u_datapath (
        .clk (clk), .rst (rst),
        .alu_op (alu_op), .alu_carry (alu_carry), .alu_oe (alu_oe),
        .t1_oe (t1_oe), .t1_we (t1_we), .t2_oe (t2_oe), .t2_we (t2_we),
        .regs_addr (regs_addr), .regs_oe (regs_oe), .regs_we (regs_we),
        .cp_oe (cp_oe), .cp_we (cp_we), .am_oe (am_oe), .am_we (am_we),
        .ram_oe (ram_oe), .ri_we (ri_we), .ind_we (ind_we),
        .mem_rdata (mem_rdata), .mem_addr (mem_addr), .ri (ri), .ind (flags),
        .reg_wr (reg_wr), .reg_wr_addr (reg_wr_addr), .reg_wr_data (reg_wr_data)
    );

endmodule

`default_nettype wire

//--- rtl/datapath.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module datapath (
    input  logic                   clk,
    input  logic                   rst,
    input  cpu_pkg::alu_op_e       alu_op,
    input  logic                   alu_carry,
    input  logic                   alu_oe,
    input  logic                   t1_oe,
    input  logic                   t1_we,
    input  logic                   t2_oe,
    input  logic                   t2_we,
    input  logic [`CPU_REG_AW-1:0] regs_addr,
    input  logic                   regs_oe,
    input  logic                   regs_we,
    input  logic                   cp_oe,
    input  logic                   cp_we,
    input  logic                   am_oe,
    input  logic                   am_we,
    input  logic                   ram_oe,
    input  logic                   ri_we,
    input  logic                   ind_we,
    input  logic [`CPU_WORD_W-1:0] mem_rdata,
    output logic [`CPU_WORD_W-1:0] mem_addr,
    output cpu_pkg::instr_t        ri,
    output logic [`CPU_WORD_W-1:0] ind,
    output logic                   reg_wr,
    output logic [`CPU_REG_AW-1:0] reg_wr_addr,
    output logic [`CPU_WORD_W-1:0] reg_wr_data
);

    logic [`CPU_WORD_W-1:0] regs [`CPU_NUM_REGS];
    logic [`CPU_WORD_W-1:0] bus;
    logic [`CPU_WORD_W-1:0] t1;
    logic [`CPU_WORD_W-1:0] t2;
    logic [`CPU_WORD_W-1:0] am;
    logic [`CPU_WORD_W-1:0] cp;
    logic [`CPU_WORD_W-1:0] alu_left;
    logic [`CPU_WORD_W-1:0] alu_right;
    logic [`CPU_WORD_W-1:0] alu_result;
    logic [3:0]             alu_flags;

    assign alu_left  = t1_oe ? t1 : '0;             // disabled latch reads as zero
    assign alu_right = t2_oe ? t2 : '0;

    alu u_alu (
        .left      (alu_left),
        .right     (alu_right),
        .op        (alu_op),
        .carry_in  (alu_carry),
        .result    (alu_result),
        .flags_out (alu_flags)
    );

    ////////////////////
    // internal bus, one source per cycle

    always_comb begin
        if (regs_oe) begin
            bus = regs[regs_addr];
        end else if (cp_oe) begin
            bus = cp;
        end else if (ram_oe) begin
            bus = mem_rdata;                        // word requested last cycle
        end else if (alu_oe) begin
            bus = alu_result;
        end else begin
            bus = '0;
        end
    end

    ////////////////////
    // registers loaded from the bus

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < `CPU_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
            t1  <= '0;
            t2  <= '0;
            am  <= '0;
            cp  <= `CPU_RESET_PC;
            ri  <= '0;
            ind <= '0;
        end else begin
            if (regs_we) regs[regs_addr] <= bus;
            if (t1_we)   t1 <= bus;
            if (t2_we)   t2 <= bus;
            if (am_we)   am <= bus;
            if (cp_we)   cp <= bus;
            if (ri_we)   ri <= bus;
            if (ind_we)  ind <= {{(`CPU_WORD_W-4){1'b0}}, alu_flags};
        end
    end

    assign mem_addr = am_oe ? am : '0;              // valid with the read strobe

    // register file write port seen from outside
    assign reg_wr      = regs_we;
    assign reg_wr_addr = regs_addr;
    assign reg_wr_data = bus;

endmodule

`default_nettype wire

//--- src.f
+incdir+rtl
rtl/cpu_pkg.sv
rtl/alu.sv
rtl/datapath.sv
rtl/control_unit.sv
rtl/cpu_top.sv
verification/tb_cpu.sv

//--- verification/tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module tb_cpu;
    import cpu_pkg::*;

    localparam int num_instr      = 200;
    localparam int mem_words      = 256;
    localparam int timeout_cycles = 16 + num_instr * 10 + 100;
    localparam int word_max       = (1 << `CPU_WORD_W) - 1;
    localparam int smax           = (1 << (`CPU_WORD_W - 1)) - 1;
    localparam int smin           = -(1 << (`CPU_WORD_W - 1));

    localparam logic [1:0] cls_undef = 2'd0;
    localparam logic [1:0] cls_mov   = 2'd1;
    localparam logic [1:0] cls_one   = 2'd2;
    localparam logic [1:0] cls_two   = 2'd3;

    logic                   clk;
    logic                   rst;
    logic [`CPU_WORD_W-1:0] mem_rdata;
    logic [`CPU_WORD_W-1:0] mem_addr;
    logic                   mem_rd;
    logic                   reg_wr;
    logic [`CPU_REG_AW-1:0] reg_wr_addr;
    logic [`CPU_WORD_W-1:0] reg_wr_data;
    logic [`CPU_WORD_W-1:0] flags;

    logic [`CPU_WORD_W-1:0] prog_mem [mem_words];
    integer                 seed;

    // reference model
    logic [`CPU_WORD_W-1:0] model_regs [`CPU_NUM_REGS];
    logic [3:0]             model_flags;
    logic [`CPU_WORD_W-1:0] model_cp;
    logic                   wr_pending;             // store still owed by current instr
    logic [`CPU_REG_AW-1:0] exp_wr_addr;
    logic [`CPU_WORD_W-1:0] exp_wr_data;
    int                     exp_gap;                // cycles until the next fetch
    string                  inflight_name;

    int                     cyc;
    int                     rise_cyc;
    int                     last_fetch;
    int                     fetch_count;
    int                     writes_seen;
    logic                   done;

    cpu_top dut (
        .clk         (clk),
        .rst         (rst),
        .mem_rdata   (mem_rdata),
        .mem_addr    (mem_addr),
        .mem_rd      (mem_rd),
        .reg_wr      (reg_wr),
        .reg_wr_addr (reg_wr_addr),
        .reg_wr_data (reg_wr_data),
        .flags       (flags)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////
    // error handling

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [`CPU_WORD_W-1:0] expected,
                               input logic [`CPU_WORD_W-1:0] actual);
        assert (actual === expected) else
            abort_run($sformatf("MISMATCH %s: expected 0x%h actual 0x%h",
                                name, expected, actual));
    endtask

    ////////////////////
    // instruction set model

    function automatic logic [1:0] classify(input instr_t w);
        logic [2:0] op;
        op = w.opcode[2:0];
        if (w.mode != 2'b11 || w.opcode[4] || op == 3'b111) return cls_undef;
        if (w.opcode[5]) return cls_two;
        if (w.opcode[3]) return cls_one;
        if (op == 3'b000) return cls_mov;
        return cls_undef;
    endfunction

    function automatic logic [3:0] make_flags(input logic [`CPU_WORD_W-1:0] res,
                                              input logic carry, input logic ovf);
        logic [3:0] f;
        f              = 4'b0000;
        f[`CPU_FLAG_C] = carry;
        f[`CPU_FLAG_Z] = (res == '0);
        f[`CPU_FLAG_S] = res[`CPU_WORD_W-1];
        f[`CPU_FLAG_O] = ovf;
        return f;
    endfunction

    // {flags, result} of a +/- b +/- cin, overflow from the true signed value
    function automatic logic [`CPU_WORD_W+3:0] arith(input logic [`CPU_WORD_W-1:0] a,
                                                     input logic [`CPU_WORD_W-1:0] b,
                                                     input logic cin, input logic sub);
        int                     ua;
        int                     ub;
        int                     ci;
        int                     total;
        int                     sr;
        logic                   c;
        logic [`CPU_WORD_W-1:0] res;
        ua = int'(a);
        ub = int'(b);
        ci = int'(cin);
        if (sub) begin
            total = ua - ub - ci;
            sr    = int'($signed(a)) - int'($signed(b)) - ci;
            c     = (total < 0);                    // borrow
        end else begin
            total = ua + ub + ci;
            sr    = int'($signed(a)) + int'($signed(b)) + ci;
            c     = (total > word_max);
        end
        res = `CPU_WORD_W'(total);
        return {make_flags(res, c, (sr > smax) || (sr < smin)), res};
    endfunction

    function automatic logic [`CPU_WORD_W+3:0] with_flags(input logic [`CPU_WORD_W-1:0] res,
                                                          input logic carry);
        return {make_flags(res, carry, 1'b0), res};
    endfunction

    task automatic expect_write(input logic [`CPU_REG_AW-1:0] addr,
                                input logic [`CPU_WORD_W-1:0] data);
        model_regs[addr] = data;
        wr_pending       = 1'b1;
        exp_wr_addr      = addr;
        exp_wr_data      = data;
    endtask

    task automatic model_step(input instr_t w, output string kind);
        logic [2:0]             op;
        logic [`CPU_REG_AW-1:0] dst;
        logic [`CPU_REG_AW-1:0] src;
        logic [`CPU_WORD_W-1:0] x;
        logic [`CPU_WORD_W-1:0] y;
        logic [`CPU_WORD_W+3:0] r;
        logic                   cf;
        op  = w.opcode[2:0];
        dst = w.d ? w.reg_f : w.rm;
        src = w.d ? w.rm : w.reg_f;
        cf  = model_flags[`CPU_FLAG_C];
        case (classify(w))
            cls_mov: begin
                expect_write(dst, model_regs[src]);
                exp_gap = 10;
                kind    = "mov";
            end
            cls_one: begin
                x = model_regs[w.rm];
                case (op)
                    3'd0:    r = arith(x, `CPU_WORD_W'(1), 1'b0, 1'b0);    // INC
                    3'd1:    r = arith(x, `CPU_WORD_W'(1), 1'b0, 1'b1);    // DEC
                    3'd2:    r = arith('0, x, 1'b0, 1'b1);                 // NEG
                    3'd3:    r = with_flags(~x, 1'b0);
                    3'd4:    r = with_flags(x << 1, x[`CPU_WORD_W-1]);
                    3'd5:    r = with_flags(x >> 1, x[0]);
                    default: r = with_flags($signed(x) >>> 1, x[0]);       // SAR
                endcase
                model_flags = r[`CPU_WORD_W+3:`CPU_WORD_W];
                expect_write(w.rm, r[`CPU_WORD_W-1:0]);
                exp_gap = 10;
                kind    = "one_op";
            end
            cls_two: begin
                x = model_regs[dst];
                y = model_regs[src];
                case (op)
                    3'd0:    r = arith(x, y, 1'b0, 1'b0);
                    3'd1:    r = arith(x, y, cf, 1'b0);
                    3'd2:    r = arith(x, y, 1'b0, 1'b1);
                    3'd3:    r = arith(x, y, cf, 1'b1);
                    3'd4:    r = with_flags(x & y, 1'b0);
                    3'd5:    r = with_flags(x | y, 1'b0);
                    default: r = with_flags(x ^ y, 1'b0);
                endcase
                model_flags = r[`CPU_WORD_W+3:`CPU_WORD_W];
                if (w.opcode[3]) begin
                    expect_write(dst, r[`CPU_WORD_W-1:0]);
                    exp_gap = 10;
                    kind    = "two_op_store";
                end else begin
                    exp_gap = 9;                    // compare form, no store
                    kind    = "compare";
                end
            end
            default: begin
                exp_gap = 6;
                kind    = "undefined";
            end
        endcase
    endtask

    ////////////////////
    // random program

    task automatic load_program();
        logic [31:0] raw;
        logic [31:0] pick;
        instr_t      w;
        for (int i = 0; i < mem_words; i++) begin
            raw  = $random(seed);
            pick = $random(seed);
            w    = raw[15:0];                       // random d, reg_f, rm, bit 15
            if (int'(pick % 100) < 85) begin
                w.mode      = 2'b11;
                w.opcode[4] = 1'b0;
                case (raw[23:22])
                    2'd0: begin                     // mov
                        w.opcode[5]   = 1'b0;
                        w.opcode[3]   = 1'b0;
                        w.opcode[2:0] = 3'b000;
                    end
                    2'd1: begin
                        w.opcode[5]   = 1'b0;
                        w.opcode[3]   = 1'b1;
                        w.opcode[2:0] = 3'(raw[20:16] % 7);
                    end
                    default: begin
                        w.opcode[5]   = 1'b1;
                        w.opcode[3]   = raw[21];    // store or compare
                        w.opcode[2:0] = 3'(raw[20:16] % 7);
                    end
                endcase
            end else begin
                case (raw[25:24])
                    2'd0:    w.mode = (raw[27:26] == 2'b11) ? 2'b00 : raw[27:26];
                    2'd1:    w.opcode[4] = 1'b1;    // immediate form
                    2'd2:    w.opcode[2:0] = 3'b111;
                    default: begin                  // one-operand class, not mov
                        w.opcode[5]   = 1'b0;
                        w.opcode[3]   = 1'b0;
                        w.opcode[2:0] = (raw[28:26] == 3'b000) ? 3'b001 : raw[28:26];
                    end
                endcase
            end
            prog_mem[i] = w;
        end
    endtask

    ////////////////////
    // memory and bus monitor

    always @(posedge clk) begin
        if (mem_rd) mem_rdata <= prog_mem[mem_addr[7:0]];
    end

    task automatic check_write();
        assert (wr_pending) else
            abort_run($sformatf("unexpected register write during %s", inflight_name));
        check_value({inflight_name, " write address"}, `CPU_WORD_W'(exp_wr_addr),
                    `CPU_WORD_W'(reg_wr_addr));
        check_value({inflight_name, " write data"}, exp_wr_data, reg_wr_data);
        wr_pending = 1'b0;
        writes_seen++;
    endtask

    task automatic check_fetch();
        string kind;
        if (fetch_count == 0) begin
            assert (cyc - rise_cyc == 2) else
                abort_run("first instruction fetch not two cycles after reset release");
        end else begin
            assert (!wr_pending) else
                abort_run($sformatf("%s ended without its register write", inflight_name));
            check_value({inflight_name, " cycles"}, `CPU_WORD_W'(exp_gap),
                        `CPU_WORD_W'(cyc - last_fetch));
        end
        check_value({inflight_name, " flags"}, `CPU_WORD_W'(model_flags), flags);
        check_value("fetch_order address", model_cp, mem_addr);
        last_fetch = cyc;
        if (fetch_count == num_instr) begin
            done = 1'b1;
        end else begin
            model_step(prog_mem[mem_addr[7:0]], kind);
            inflight_name = $sformatf("%s #%0d", kind, fetch_count);
            model_cp      = model_cp + `CPU_WORD_W'(1);
            fetch_count++;
        end
    endtask

    always @(posedge clk) begin
        cyc = cyc + 1;
        if (!rst) begin
            if (cyc > 1) begin                      // state is known after one edge
                assert (!mem_rd && !reg_wr) else
                    abort_run("memory read or register write while reset is held");
            end
        end else if (!done) begin
            if (rise_cyc < 0) rise_cyc = cyc;
            if (reg_wr) check_write();
            if (mem_rd) check_fetch();
        end
    end

    ////////////////////
    // main sequence

    initial begin
        rst           = 1'b0;
        mem_rdata     = '0;
        seed          = 69054;
        model_flags   = '0;
        model_cp      = `CPU_RESET_PC;
        wr_pending    = 1'b0;
        exp_wr_addr   = '0;
        exp_wr_data   = '0;
        exp_gap       = 0;
        inflight_name = "reset";
        cyc           = 0;
        rise_cyc      = -1;
        last_fetch    = 0;
        fetch_count   = 0;
        writes_seen   = 0;
        done          = 1'b0;
        for (int i = 0; i < `CPU_NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        load_program();

        repeat (16) @(posedge clk);
        rst <= 1'b1;

        while (!done && cyc < timeout_cycles) @(negedge clk);
        if (done) begin
            $display("%0d instructions and %0d register writes checked",
                     num_instr, writes_seen);
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            abort_run($sformatf("timeout after %0d cycles with %0d instructions fetched",
                                cyc, fetch_count));
        end
    end

endmodule

`default_nettype wire
